/* mesh_cfg_pkg.sv */
/*
 * mesh geometry, datapath widths and hop directions for the
 * 3x3 calculator mesh, tile index is y * MESH_DIM + x
 */
package mesh_cfg_pkg;

    // --------------------------------------------------
    // datapath and geometry
    // --------------------------------------------------
    localparam int DATA_W    = 64;
    localparam int MESH_DIM  = 3;
    localparam int NUM_TILES = MESH_DIM * MESH_DIM;

    // enough for coordinates 0 to MESH_DIM-1
    localparam int COORD_W   = 2;

    // --------------------------------------------------
    // hop direction of a flit leaving a tile
    // --------------------------------------------------
    typedef enum logic [2:0] {
        DIR_NONE  = 3'd0,
        DIR_NORTH = 3'd1,
        DIR_EAST  = 3'd2,
        DIR_SOUTH = 3'd3,
        DIR_WEST  = 3'd4,
        // response delivered to the host at the origin
        DIR_HOST  = 3'd5
    } dir_e;

endpackage

/* alu_op_pkg.sv */
/*
 * calculator operations: opcode encoding, mode decoding limits
 * and the host handshake states
 */
package alu_op_pkg;

    localparam int OP_W      = 4;
    // only the low bits of b count as shift amount
    localparam int SHIFT_W   = 6;
    // modes 0 to 8 map onto the nine tiles
    localparam int NUM_MODES = 9;

    // --------------------------------------------------
    // opcodes, equal to the mode that selects them
    // --------------------------------------------------
    typedef enum logic [OP_W-1:0] {
        OP_ADD      = 4'd0,
        OP_SUB      = 4'd1,
        OP_MUL      = 4'd2,
        // division is not built, result is zero
        OP_DIV_NONE = 4'd3,
        OP_AND      = 4'd4,
        OP_OR       = 4'd5,
        OP_XOR      = 4'd6,
        OP_SHL      = 4'd7,
        OP_SHR      = 4'd8,
        OP_NONE     = 4'd15
    } alu_op_e;

    // four-phase req/ack FSM
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_INJECT,
        HS_WAIT,
        HS_ACK
    } hs_state_e;

endpackage

/* flit_injector.sv */
/*
 * request injector: captures the host operands on inject, decodes the
 * mode into destination tile and opcode, presents one request flit
 */
module flit_injector (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             inject,
    input  logic [mesh_cfg_pkg::DATA_W-1:0]  a,
    input  logic [mesh_cfg_pkg::DATA_W-1:0]  b,
    input  logic [alu_op_pkg::OP_W-1:0]      mode,
    output logic                             inj_valid,
    output logic [mesh_cfg_pkg::DATA_W-1:0]  inj_a,
    output logic [mesh_cfg_pkg::DATA_W-1:0]  inj_b,
    output alu_op_pkg::alu_op_e              inj_op,
    output logic [mesh_cfg_pkg::COORD_W-1:0] inj_dst_x,
    output logic [mesh_cfg_pkg::COORD_W-1:0] inj_dst_y
);
    import mesh_cfg_pkg::*;
    import alu_op_pkg::*;

    alu_op_e            dec_op;
    logic [COORD_W-1:0] dec_x;
    logic [COORD_W-1:0] dec_y;

    // mode n goes to tile (n mod 3, n div 3) with opcode n
    always_comb begin
        if (mode < OP_W'(NUM_MODES)) begin
            dec_op = alu_op_e'(mode);
            dec_x  = COORD_W'(mode % OP_W'(MESH_DIM));
            dec_y  = COORD_W'(mode / OP_W'(MESH_DIM));
        end else begin
            // unrouted modes stay at the origin and return zero
            dec_op = OP_NONE;
            dec_x  = '0;
            dec_y  = '0;
        end
    end

    // flit valid follows the inject pulse by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inj_valid <= 1'b0;
        end else begin
            inj_valid <= inject;
        end
    end

    // operands and decoded header, held until the next inject
    always_ff @(posedge clk) begin
        if (inject) begin
            inj_a     <= a;
            inj_b     <= b;
            inj_op    <= dec_op;
            inj_dst_x <= dec_x;
            inj_dst_y <= dec_y;
        end
    end

endmodule

/* alu_tile.sv */
/*
 * mesh tile: one flit register, dimension-order route decision and
 * the 64-bit ALU that turns a request at this tile into a response
 */
module alu_tile #(
    parameter int TILE_X = 0,
    parameter int TILE_Y = 0
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // neighbor bundles, each with the valid that points at this tile
    input  logic [mesh_cfg_pkg::DATA_W-1:0]  n_a, e_a, s_a, w_a,
    input  logic [mesh_cfg_pkg::DATA_W-1:0]  n_b, e_b, s_b, w_b,
    input  alu_op_pkg::alu_op_e              n_op, e_op, s_op, w_op,
    input  logic [mesh_cfg_pkg::COORD_W-1:0] n_dst_x, e_dst_x, s_dst_x, w_dst_x,
    input  logic [mesh_cfg_pkg::COORD_W-1:0] n_dst_y, e_dst_y, s_dst_y, w_dst_y,
    input  logic                             n_resp, e_resp, s_resp, w_resp,
    input  logic                             n_valid, e_valid, s_valid, w_valid,
    // host side request input
    input  logic                             host_in_valid,
    input  logic [mesh_cfg_pkg::DATA_W-1:0]  host_in_a,
    input  logic [mesh_cfg_pkg::DATA_W-1:0]  host_in_b,
    input  alu_op_pkg::alu_op_e              host_in_op,
    input  logic [mesh_cfg_pkg::COORD_W-1:0] host_in_dst_x,
    input  logic [mesh_cfg_pkg::COORD_W-1:0] host_in_dst_y,
    // own flit bundle, seen by all four neighbors
    output logic [mesh_cfg_pkg::DATA_W-1:0]  flit_a,
    output logic [mesh_cfg_pkg::DATA_W-1:0]  flit_b,
    output alu_op_pkg::alu_op_e              flit_op,
    output logic [mesh_cfg_pkg::COORD_W-1:0] flit_dst_x,
    output logic [mesh_cfg_pkg::COORD_W-1:0] flit_dst_y,
    output logic                             flit_resp,
    output logic                             valid_n, valid_e, valid_s, valid_w,
    output logic                             host_valid
);
    import mesh_cfg_pkg::*;
    import alu_op_pkg::*;

    localparam logic [COORD_W-1:0] MY_X = COORD_W'(TILE_X);
    localparam logic [COORD_W-1:0] MY_Y = COORD_W'(TILE_Y);

    logic               occupied;
    logic               in_any;
    logic [DATA_W-1:0]  in_a;
    logic [DATA_W-1:0]  in_b;
    alu_op_e            in_op;
    logic [COORD_W-1:0] in_dst_x;
    logic [COORD_W-1:0] in_dst_y;
    logic               in_resp;
    logic               at_dst;
    logic [DATA_W-1:0]  alu_res;
    dir_e               dir;

    // --------------------------------------------------
    // input select, one packet means one valid at most
    // --------------------------------------------------
    assign in_any   = n_valid | e_valid | s_valid | w_valid | host_in_valid;
    assign in_a     = n_valid ? n_a : e_valid ? e_a : s_valid ? s_a : w_valid ? w_a : host_in_a;
    assign in_b     = n_valid ? n_b : e_valid ? e_b : s_valid ? s_b : w_valid ? w_b : host_in_b;
    assign in_op    = n_valid ? n_op : e_valid ? e_op : s_valid ? s_op :
                      w_valid ? w_op : host_in_op;
    assign in_dst_x = n_valid ? n_dst_x : e_valid ? e_dst_x : s_valid ? s_dst_x :
                      w_valid ? w_dst_x : host_in_dst_x;
    assign in_dst_y = n_valid ? n_dst_y : e_valid ? e_dst_y : s_valid ? s_dst_y :
                      w_valid ? w_dst_y : host_in_dst_y;
    // host flits are always requests
    assign in_resp  = n_valid ? n_resp : e_valid ? e_resp : s_valid ? s_resp :
                      w_valid ? w_resp : 1'b0;

    assign at_dst = occupied && !flit_resp && (flit_dst_x == MY_X) && (flit_dst_y == MY_Y);

    always_comb begin
        case (flit_op)
            OP_ADD:  alu_res = flit_a + flit_b;
            OP_SUB:  alu_res = flit_a - flit_b;
            OP_MUL:  alu_res = flit_a * flit_b;
            OP_AND:  alu_res = flit_a & flit_b;
            OP_OR:   alu_res = flit_a | flit_b;
            OP_XOR:  alu_res = flit_a ^ flit_b;
            OP_SHL:  alu_res = flit_a << flit_b[SHIFT_W-1:0];
            OP_SHR:  alu_res = flit_a >> flit_b[SHIFT_W-1:0];
            default: alu_res = '0;
        endcase
    end

    // --------------------------------------------------
    // route decision
    // --------------------------------------------------
    always_comb begin
        dir = DIR_NONE;
        if (occupied && !flit_resp) begin
            // requests go along Y first, then along X
            if (flit_dst_y > MY_Y)
                dir = DIR_SOUTH;
            else if (flit_dst_y < MY_Y)
                dir = DIR_NORTH;
            else if (flit_dst_x > MY_X)
                dir = DIR_EAST;
            else if (flit_dst_x < MY_X)
                dir = DIR_WEST;
        end else if (occupied) begin
            // responses go north, then west, then out to the host
            if (TILE_Y > 0)
                dir = DIR_NORTH;
            else if (TILE_X > 0)
                dir = DIR_WEST;
            else
                dir = DIR_HOST;
        end
    end

    assign valid_n    = (dir == DIR_NORTH);
    assign valid_e    = (dir == DIR_EAST);
    assign valid_s    = (dir == DIR_SOUTH);
    assign valid_w    = (dir == DIR_WEST);
    assign host_valid = (dir == DIR_HOST);

    // a flit leaves after one cycle, a request at its destination stays two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied  <= 1'b0;
            flit_resp <= 1'b0;
        end else if (in_any) begin
            occupied  <= 1'b1;
            flit_resp <= in_resp;
        end else if (at_dst) begin
            flit_resp <= 1'b1;
        end else if (dir != DIR_NONE) begin
            occupied <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_any) begin
            flit_a     <= in_a;
            flit_b     <= in_b;
            flit_op    <= in_op;
            flit_dst_x <= in_dst_x;
            flit_dst_y <= in_dst_y;
        end else if (at_dst) begin
            // the response carries the result in the a field
            flit_a <= alu_res;
        end
    end

endmodule

/* tile_mesh.sv */
/*
 * 3x3 grid of ALU tiles with neighbor links, requests enter and
 * responses leave through the host port of tile (0,0)
 */
module tile_mesh (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             inj_valid,
    input  logic [mesh_cfg_pkg::DATA_W-1:0]  inj_a,
    input  logic [mesh_cfg_pkg::DATA_W-1:0]  inj_b,
    input  alu_op_pkg::alu_op_e              inj_op,
    input  logic [mesh_cfg_pkg::COORD_W-1:0] inj_dst_x,
    input  logic [mesh_cfg_pkg::COORD_W-1:0] inj_dst_y,
    output logic                             resp_valid,
    output logic [mesh_cfg_pkg::DATA_W-1:0]  resp_data
);
    import mesh_cfg_pkg::*;
    import alu_op_pkg::*;

    // per-tile flit bundles
    logic [DATA_W-1:0]  t_a     [NUM_TILES];
    logic [DATA_W-1:0]  t_b     [NUM_TILES];
    alu_op_e            t_op    [NUM_TILES];
    logic [COORD_W-1:0] t_dst_x [NUM_TILES];
    logic [COORD_W-1:0] t_dst_y [NUM_TILES];
    logic               t_resp  [NUM_TILES];

    // per-tile directional valids
    logic               v_n     [NUM_TILES];
    logic               v_e     [NUM_TILES];
    logic               v_s     [NUM_TILES];
    logic               v_w     [NUM_TILES];
    logic               v_host  [NUM_TILES];

    // --------------------------------------------------
    // grid
    // --------------------------------------------------
    for (genvar y = 0; y < MESH_DIM; y++) begin : g_row
        for (genvar x = 0; x < MESH_DIM; x++) begin : g_col
            localparam int IDX   = y * MESH_DIM + x;
            // on an edge the missing neighbor index points back at this tile
            localparam int N_IDX = (y > 0) ? IDX - MESH_DIM : IDX;
            localparam int E_IDX = (x < MESH_DIM - 1) ? IDX + 1 : IDX;
            localparam int S_IDX = (y < MESH_DIM - 1) ? IDX + MESH_DIM : IDX;
            localparam int W_IDX = (x > 0) ? IDX - 1 : IDX;

            alu_tile #(
                .TILE_X(x),
                .TILE_Y(y)
            ) u_tile (
                .clk(clk),
                .rst_n(rst_n),
                .n_a(t_a[N_IDX]), .n_b(t_b[N_IDX]), .n_op(t_op[N_IDX]),
                .n_dst_x(t_dst_x[N_IDX]), .n_dst_y(t_dst_y[N_IDX]), .n_resp(t_resp[N_IDX]),
                .e_a(t_a[E_IDX]), .e_b(t_b[E_IDX]), .e_op(t_op[E_IDX]),
                .e_dst_x(t_dst_x[E_IDX]), .e_dst_y(t_dst_y[E_IDX]), .e_resp(t_resp[E_IDX]),
                .s_a(t_a[S_IDX]), .s_b(t_b[S_IDX]), .s_op(t_op[S_IDX]),
                .s_dst_x(t_dst_x[S_IDX]), .s_dst_y(t_dst_y[S_IDX]), .s_resp(t_resp[S_IDX]),
                .w_a(t_a[W_IDX]), .w_b(t_b[W_IDX]), .w_op(t_op[W_IDX]),
                .w_dst_x(t_dst_x[W_IDX]), .w_dst_y(t_dst_y[W_IDX]), .w_resp(t_resp[W_IDX]),
                // each neighbor's valid facing this tile, edges tied inactive
                .n_valid((y > 0) ? v_s[N_IDX] : 1'b0),
                .e_valid((x < MESH_DIM - 1) ? v_w[E_IDX] : 1'b0),
                .s_valid((y < MESH_DIM - 1) ? v_n[S_IDX] : 1'b0),
                .w_valid((x > 0) ? v_e[W_IDX] : 1'b0),
                // only the origin takes host requests
                .host_in_valid((IDX == 0) ? inj_valid : 1'b0),
                .host_in_a(inj_a),
                .host_in_b(inj_b),
                .host_in_op(inj_op),
                .host_in_dst_x(inj_dst_x),
                .host_in_dst_y(inj_dst_y),
                .flit_a(t_a[IDX]),
                .flit_b(t_b[IDX]),
                .flit_op(t_op[IDX]),
                .flit_dst_x(t_dst_x[IDX]),
                .flit_dst_y(t_dst_y[IDX]),
                .flit_resp(t_resp[IDX]),
                .valid_n(v_n[IDX]),
                .valid_e(v_e[IDX]),
                .valid_s(v_s[IDX]),
                .valid_w(v_w[IDX]),
                .host_valid(v_host[IDX])
            );
        end
    end

    assign resp_valid = v_host[0];
    assign resp_data  = t_a[0];

endmodule

/* host_handshake.sv */
/*
 * host side four-phase req/ack FSM, pulses inject for each new
 * request and holds the returned result until the next ack
 */
module host_handshake (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req,
    input  logic                            resp_valid,
    input  logic [mesh_cfg_pkg::DATA_W-1:0] resp_data,
    output logic                            ack,
    output logic [mesh_cfg_pkg::DATA_W-1:0] result,
    output logic                            inject
);
    import alu_op_pkg::*;

    hs_state_e state;
    hs_state_e state_nxt;

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            HS_IDLE: begin
                if (req)
                    state_nxt = HS_INJECT;
            end
            HS_INJECT: state_nxt = HS_WAIT;
            HS_WAIT: begin
                // packet is in the mesh
                if (resp_valid)
                    state_nxt = HS_ACK;
            end
            HS_ACK: begin
                // hold ack until the host releases req
                if (!req)
                    state_nxt = HS_IDLE;
            end
            default: state_nxt = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= HS_IDLE;
            result <= '0;
        end else begin
            state <= state_nxt;
            if (state == HS_WAIT && resp_valid)
                result <= resp_data;
        end
    end

    assign inject = (state == HS_INJECT);
    assign ack    = (state == HS_ACK);

endmodule

/* mesh_calc_top.sv */
/*
 * mesh calculator top: host handshake, request injector and the
 * 3x3 tile mesh
 */
module mesh_calc_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req,
    input  logic [mesh_cfg_pkg::DATA_W-1:0] a,
    input  logic [mesh_cfg_pkg::DATA_W-1:0] b,
    input  logic [alu_op_pkg::OP_W-1:0]     mode,
    output logic                            ack,
    output logic [mesh_cfg_pkg::DATA_W-1:0] result
);
    import mesh_cfg_pkg::*;
    import alu_op_pkg::*;

    logic               inject;
    logic               inj_valid;
    logic [DATA_W-1:0]  inj_a;
    logic [DATA_W-1:0]  inj_b;
    alu_op_e            inj_op;
    logic [COORD_W-1:0] inj_dst_x;
    logic [COORD_W-1:0] inj_dst_y;
    logic               resp_valid;
    logic [DATA_W-1:0]  resp_data;

    host_handshake u_hs (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .resp_valid(resp_valid),
        .resp_data(resp_data),
        .ack(ack),
        .result(result),
        .inject(inject)
    );

    flit_injector u_inj (
        .clk(clk),
        .rst_n(rst_n),
        .inject(inject),
        .a(a),
        .b(b),
        .mode(mode),
        .inj_valid(inj_valid),
        .inj_a(inj_a),
        .inj_b(inj_b),
        .inj_op(inj_op),
        .inj_dst_x(inj_dst_x),
        .inj_dst_y(inj_dst_y)
    );

    tile_mesh u_mesh (
        .clk(clk),
        .rst_n(rst_n),
        .inj_valid(inj_valid),
        .inj_a(inj_a),
        .inj_b(inj_b),
        .inj_op(inj_op),
        .inj_dst_x(inj_dst_x),
        .inj_dst_y(inj_dst_y),
        .resp_valid(resp_valid),
        .resp_data(resp_data)
    );

endmodule

/* mesh_calc_tb_tasks.svh */
/*
 * testbench helpers: value compare, timeout report, idle cycles
 * and the waits on the ack edges
 */
`ifndef MESH_CALC_TB_TASKS_SVH
`define MESH_CALC_TB_TASKS_SVH

    // stops at the first mismatch
    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("no %s within %0d clock cycles at time %0t", what, TIMEOUT_CYCLES, $time);
        $display("Simulation failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // result keeps the previous value until ack rises
    task automatic wait_ack_rise(input logic [DATA_W-1:0] old_result);
        int n;
        n = 0;
        while (!ack) begin
            if (n == TIMEOUT_CYCLES) begin
                report_timeout("rising ack");
            end else begin
                check_value("result", result, old_result);
                @(posedge clk);
                #1;
                n++;
            end
        end
    endtask

    task automatic wait_ack_fall();
        int n;
        n = 0;
        while (ack) begin
            if (n == TIMEOUT_CYCLES) begin
                report_timeout("falling ack after req was released");
            end else begin
                @(posedge clk);
                #1;
                n++;
            end
        end
    endtask

`endif

/* mesh_calc_tb.sv */
/*
 * testbench for the mesh calculator, replays the vectors of the
 * test data file over the four-phase req/ack handshake
 */
module mesh_calc_tb;
    import mesh_cfg_pkg::*;
    import alu_op_pkg::*;

    localparam int MAX_VECS       = 64;
    localparam int TIMEOUT_CYCLES = 100;

    logic              clk;
    logic              rst_n;
    logic              req;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [OP_W-1:0]   mode;
    logic              ack;
    logic [DATA_W-1:0] result;

    // four words per vector: a, b, mode, expected result
    logic [DATA_W-1:0] vec_mem [0:4*MAX_VECS-1];
    logic [DATA_W-1:0] prev_result;
    logic [DATA_W-1:0] exp_result;
    int                seed_val;
    int                num_vecs;
    int                hold_cycles;

    mesh_calc_top uut (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .a(a),
        .b(b),
        .mode(mode),
        .ack(ack),
        .result(result)
    );

    `include "mesh_calc_tb_tasks.svh"

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // --------------------------------------------------
    // stimulus and checks
    // --------------------------------------------------
    initial begin
        req         = 1'b0;
        a           = '0;
        b           = '0;
        mode        = '0;
        rst_n       = 1'b0;
        prev_result = '0;
        seed_val    = $urandom(94573);
        $readmemh("mesh_calc_testdata.txt", vec_mem);

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("ack", ack, 0);
        check_value("result", result, 0);

        num_vecs = 0;
        while (num_vecs < MAX_VECS && !$isunknown(vec_mem[4*num_vecs]))
            num_vecs++;
        if (num_vecs == 0) begin
            $display("no test vectors could be read from the test data file");
            $display("Simulation failed");
            $fatal(1, "empty stimulus");
        end

        for (int i = 0; i < num_vecs; i++) begin
            idle_gap($urandom % 6);
            a          = vec_mem[4*i];
            b          = vec_mem[4*i+1];
            mode       = vec_mem[4*i+2][OP_W-1:0];
            exp_result = vec_mem[4*i+3];
            req        = 1'b1;
            wait_ack_rise(prev_result);
            check_value("result", result, exp_result);

            // host keeps req high a while, ack and result must hold
            hold_cycles = 1 + ($urandom % 5);
            repeat (hold_cycles) begin
                @(posedge clk);
                #1;
                check_value("ack", ack, 1);
                check_value("result", result, exp_result);
            end

            req = 1'b0;
            wait_ack_fall();
            check_value("result", result, exp_result);
            prev_result = exp_result;
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* mesh_calc_testdata.txt */
// columns: a b mode expected_result, all in hex, one transaction per line
// expected is the 64-bit result of the mode's operation, zero for mode 3 and modes 9 to f
0000000000001234 0000000000000111 0 0000000000001345
ffffffffffffffff 0000000000000002 0 0000000000000001
0000000000000010 0000000000000003 1 000000000000000d
0000000000000000 0000000000000001 1 ffffffffffffffff
0000000000000064 0000000000000005 3 0000000000000000
0000000000000007 0000000000000006 2 000000000000002a
8000000000000001 0000000000000004 2 0000000000000004
0000000100000000 0000000100000003 2 0000000300000000
f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 4 f000f000f000f000
f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 5 fff0fff0fff0fff0
0000000000000001 0000000000000002 9 0000000000000000
f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 6 0ff00ff00ff00ff0
0000000000000001 000000000000003f 7 8000000000000000
0000000000000001 0000000000000044 7 0000000000000010
00000000000000ff 0000000000000008 7 000000000000ff00
8000000000000000 000000000000003f 8 0000000000000001
0000000000000005 0000000000000005 c 0000000000000000
000000000000ff00 0000000000000108 8 00000000000000ff
0000000000000123 0000000000000456 f 0000000000000000

/* mesh_calc.f */
+incdir+.
mesh_cfg_pkg.sv
alu_op_pkg.sv
flit_injector.sv
alu_tile.sv
tile_mesh.sv
host_handshake.sv
mesh_calc_top.sv
mesh_calc_tb.sv
